// File: src/hdd_pkg.sv
// ----------------------------------------------------------------------
// HDD interface package
// Widths, register offsets, ProDOS command and status codes, and the
// access record passed from the bus decoder to the register blocks
// ----------------------------------------------------------------------

package hdd_pkg;

    localparam int DATA_W        = 8;   // 6502 data bus
    localparam int SECTOR_ADDR_W = 9;   // 512-byte block
    localparam int BLOCK_W       = 16;  // ProDOS block number

    // ------------------------------------------------------------------
    // CPU register offsets within the device window
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        REG_EXEC      = 4'h0,   // Read executes command, returns status
        REG_STATUS    = 4'h1,
        REG_COMMAND   = 4'h2,
        REG_UNIT      = 4'h3,
        REG_MEM_L     = 4'h4,
        REG_MEM_H     = 4'h5,
        REG_BLOCK_L   = 4'h6,
        REG_BLOCK_H   = 4'h7,
        REG_NEXT_BYTE = 4'h8    // Sector buffer stream
    } hdd_reg_sel_e;

    // ------------------------------------------------------------------
    // ProDOS commands and status codes
    // ------------------------------------------------------------------
    typedef enum logic [7:0] {
        CMD_STATUS = 8'h00,
        CMD_READ   = 8'h01,
        CMD_WRITE  = 8'h02,
        CMD_FORMAT = 8'h03      // Stored only
    } hdd_cmd_e;

    localparam logic [DATA_W-1:0] STATUS_OK      = 8'h00;
    localparam logic [DATA_W-1:0] STATUS_ERROR   = 8'h01;
    localparam logic [DATA_W-1:0] STATUS_BUSY    = 8'h80;
    localparam logic [DATA_W-1:0] STATUS_PROTECT = 8'h2B;

    // One decoded CPU access, valid for a single clock
    typedef struct packed {
        logic              valid;
        logic              is_read;
        hdd_reg_sel_e      sel;
        logic [DATA_W-1:0] wdata;
    } hdd_access_t;

endpackage

// File: src/hdd_bus_decode.sv
// ----------------------------------------------------------------------
// HDD bus decoder
// Samples the 6502 bus and emits one access record per device select
// ----------------------------------------------------------------------

module hdd_bus_decode (
    input  logic                        CLK_14M,
    input  logic                        RESET,
    input  logic                        phi0,
    input  logic                        DEVICE_SELECT,
    input  logic                        RD,
    input  logic [15:0]                 A,
    input  logic [hdd_pkg::DATA_W-1:0]  D_IN,
    output hdd_pkg::hdd_access_t        acc
);

    logic sel_d;        // Select as seen on the previous clock
    logic start;

    // Only the low nibble of A picks the register
    assign start = DEVICE_SELECT && phi0 && !sel_d;

    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            sel_d     <= 1'b0;
            acc.valid <= 1'b0;
        end
        else
        begin
            sel_d     <= DEVICE_SELECT;
            acc.valid <= start;     // One clock per select
        end

        // Payload follows the bus every clock
        acc.is_read <= RD;
        acc.sel     <= hdd_pkg::hdd_reg_sel_e'(A[3:0]);
        acc.wdata   <= D_IN;
    end

endmodule

// File: src/hdd_regs.sv
// ----------------------------------------------------------------------
// HDD parameter registers
// Unit, memory and block registers plus the registered CPU read mux
// ----------------------------------------------------------------------

module hdd_regs (
    input  logic                        CLK_14M,
    input  logic                        RESET,
    input  logic                        DEVICE_SELECT,
    input  hdd_pkg::hdd_access_t        acc,
    input  logic [hdd_pkg::DATA_W-1:0]  status,
    input  logic [hdd_pkg::DATA_W-1:0]  command,
    input  logic [hdd_pkg::DATA_W-1:0]  exec_rdata,
    input  logic [hdd_pkg::DATA_W-1:0]  buf_rdata,
    output logic [hdd_pkg::BLOCK_W-1:0] sector,
    output logic [hdd_pkg::DATA_W-1:0]  D_OUT
);

    logic [hdd_pkg::DATA_W-1:0] reg_unit;
    logic [hdd_pkg::DATA_W-1:0] reg_mem_l;
    logic [hdd_pkg::DATA_W-1:0] reg_mem_h;
    logic [hdd_pkg::DATA_W-1:0] reg_block_l;
    logic [hdd_pkg::DATA_W-1:0] reg_block_h;

    hdd_pkg::hdd_reg_sel_e      rd_sel;     // Offset of the last read
    logic                       rd_pend;
    logic                       sel_q;
    logic [hdd_pkg::DATA_W-1:0] rd_mux;

    assign sector = {reg_block_h, reg_block_l};

    // ------------------------------------------------------------------
    // CPU writes
    // ------------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            reg_unit    <= '0;
            reg_mem_l   <= '0;
            reg_mem_h   <= '0;
            reg_block_l <= '0;
            reg_block_h <= '0;
        end
        else if (acc.valid && !acc.is_read)
        begin
            case (acc.sel)
                hdd_pkg::REG_UNIT:    reg_unit    <= acc.wdata;
                hdd_pkg::REG_MEM_L:   reg_mem_l   <= acc.wdata;
                hdd_pkg::REG_MEM_H:   reg_mem_h   <= acc.wdata;
                hdd_pkg::REG_BLOCK_L: reg_block_l <= acc.wdata;
                hdd_pkg::REG_BLOCK_H: reg_block_h <= acc.wdata;
                default: ;              // Command side handles the rest
            endcase
        end
    end

    // ------------------------------------------------------------------
    // CPU read data
    // ------------------------------------------------------------------
    always_comb
    begin
        case (rd_sel)
            hdd_pkg::REG_EXEC:      rd_mux = exec_rdata;
            hdd_pkg::REG_STATUS:    rd_mux = status;
            hdd_pkg::REG_COMMAND:   rd_mux = command;
            hdd_pkg::REG_UNIT:      rd_mux = reg_unit;
            hdd_pkg::REG_MEM_L:     rd_mux = reg_mem_l;
            hdd_pkg::REG_MEM_H:     rd_mux = reg_mem_h;
            hdd_pkg::REG_BLOCK_L:   rd_mux = reg_block_l;
            hdd_pkg::REG_BLOCK_H:   rd_mux = reg_block_h;
            hdd_pkg::REG_NEXT_BYTE: rd_mux = buf_rdata;
            default:                rd_mux = '1;
        endcase
    end

    // Captured once per read so NEXT BYTE stays stable
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            sel_q   <= 1'b0;
            rd_pend <= 1'b0;
            D_OUT   <= '1;
        end
        else
        begin
            sel_q   <= DEVICE_SELECT;
            rd_pend <= acc.valid && acc.is_read;
            if (!sel_q)
                D_OUT <= '1;            // Idle bus reads FF
            else if (rd_pend)
                D_OUT <= rd_mux;
        end

        if (acc.valid)
            rd_sel <= acc.sel;
    end

endmodule

// File: src/hdd_cmd_ctrl.sv
// ----------------------------------------------------------------------
// HDD command control
// Command and status registers, execute-on-read, host strobes and the
// sector buffer pointer for the NEXT BYTE stream
// ----------------------------------------------------------------------

module hdd_cmd_ctrl (
    input  logic                              CLK_14M,
    input  logic                              RESET,
    input  hdd_pkg::hdd_access_t              acc,
    input  logic                              hdd_mounted,
    input  logic                              hdd_protect,
    output logic [hdd_pkg::DATA_W-1:0]        status,
    output logic [hdd_pkg::DATA_W-1:0]        command,
    output logic [hdd_pkg::DATA_W-1:0]        exec_rdata,
    output logic [hdd_pkg::SECTOR_ADDR_W-1:0] sec_ptr,
    output logic                              buf_we,
    output logic [hdd_pkg::DATA_W-1:0]        buf_wdata,
    output logic                              hdd_read,
    output logic                              hdd_write
);

    logic cmd_wr;       // Write to COMMAND
    logic exec_rd;      // Read of offset 0
    logic next_acc;     // Either direction of NEXT BYTE
    logic is_xfer;
    logic wr_protected;

    assign cmd_wr   = acc.valid && !acc.is_read && (acc.sel == hdd_pkg::REG_COMMAND);
    assign exec_rd  = acc.valid && acc.is_read && (acc.sel == hdd_pkg::REG_EXEC);
    assign next_acc = acc.valid && (acc.sel == hdd_pkg::REG_NEXT_BYTE);

    assign is_xfer = (acc.wdata == hdd_pkg::CMD_READ) || (acc.wdata == hdd_pkg::CMD_WRITE);
    assign wr_protected = (command == hdd_pkg::CMD_WRITE) && hdd_protect;

    // Buffer write lands on the current pointer before it advances
    assign buf_we    = next_acc && !acc.is_read;
    assign buf_wdata = acc.wdata;

    // ------------------------------------------------------------------
    // Command, status, pointer and strobes
    // ------------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            status    <= hdd_pkg::STATUS_OK;
            command   <= hdd_pkg::CMD_STATUS;
            sec_ptr   <= '0;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;
        end
        else
        begin
            hdd_read  <= 1'b0;      // Strobes last one clock
            hdd_write <= 1'b0;

            if (cmd_wr)
            begin
                command <= acc.wdata;
                sec_ptr <= '0;
                status  <= is_xfer ? hdd_pkg::STATUS_BUSY : hdd_pkg::STATUS_OK;
            end
            else if (exec_rd)
            begin
                case (command)
                    hdd_pkg::CMD_STATUS:
                        status <= hdd_mounted ? hdd_pkg::STATUS_OK : hdd_pkg::STATUS_ERROR;
                    hdd_pkg::CMD_READ:
                    begin
                        if (hdd_mounted)
                            hdd_read <= 1'b1;
                        else
                            status <= hdd_pkg::STATUS_ERROR;
                    end
                    hdd_pkg::CMD_WRITE:
                    begin
                        if (hdd_mounted && !hdd_protect)
                            hdd_write <= 1'b1;
                        else
                            status <= hdd_pkg::STATUS_ERROR;    // Missing or protected
                    end
                    hdd_pkg::CMD_FORMAT: ;      // Accepted, nothing to run
                    default: ;
                endcase
            end
            else if (next_acc)
            begin
                sec_ptr <= sec_ptr + 1'b1;
                // Last byte of a read clears busy
                if (acc.is_read && (sec_ptr == '1))
                    status <= hdd_pkg::STATUS_OK;
            end
        end
    end

    // Value returned by the execute read, status before the update
    always_ff @(posedge CLK_14M)
    begin
        if (exec_rd)
            exec_rdata <= wr_protected ? hdd_pkg::STATUS_PROTECT : status;
    end

endmodule

// File: src/sector_buffer.sv
// ----------------------------------------------------------------------
// Sector buffer
// 512 x 8 true dual-port RAM, CPU stream on one port, host DMA on other
// ----------------------------------------------------------------------

module sector_buffer (
    input  logic                              CLK_14M,
    input  logic [hdd_pkg::SECTOR_ADDR_W-1:0] ptr,
    input  logic                              we,
    input  logic [hdd_pkg::DATA_W-1:0]        wdata,
    output logic [hdd_pkg::DATA_W-1:0]        rdata,
    input  logic [hdd_pkg::SECTOR_ADDR_W-1:0] ram_addr,
    input  logic [hdd_pkg::DATA_W-1:0]        ram_di,
    input  logic                              ram_we,
    output logic [hdd_pkg::DATA_W-1:0]        ram_do
);

    logic [hdd_pkg::DATA_W-1:0] mem [0:(1 << hdd_pkg::SECTOR_ADDR_W)-1];
    logic [hdd_pkg::DATA_W-1:0] dma_q;

    // CPU port, read before write
    always @(posedge CLK_14M)
    begin
        if (we)
            mem[ptr] <= wdata;
        rdata <= mem[ptr];
    end

    // DMA port
    always @(posedge CLK_14M)
    begin
        if (ram_we)
            mem[ram_addr] <= ram_di;
        dma_q <= mem[ram_addr];
    end

    always_ff @(posedge CLK_14M)
    begin
        ram_do <= dma_q;        // Extra stage on host readback
    end

endmodule

// File: src/hdd_top.sv
// ----------------------------------------------------------------------
// HDD interface top
// ProDOS hard disk registers, command logic and sector buffer
// ----------------------------------------------------------------------

module hdd_top (
    input  logic                              CLK_14M,
    input  logic                              RESET,
    input  logic                              phi0,
    input  logic                              DEVICE_SELECT,
    input  logic                              RD,
    input  logic [15:0]                       A,
    input  logic [hdd_pkg::DATA_W-1:0]        D_IN,
    output logic [hdd_pkg::DATA_W-1:0]        D_OUT,
    output logic [hdd_pkg::BLOCK_W-1:0]       sector,
    output logic                              hdd_read,
    output logic                              hdd_write,
    input  logic                              hdd_mounted,
    input  logic                              hdd_protect,
    input  logic [hdd_pkg::SECTOR_ADDR_W-1:0] ram_addr,
    input  logic [hdd_pkg::DATA_W-1:0]        ram_di,
    output logic [hdd_pkg::DATA_W-1:0]        ram_do,
    input  logic                              ram_we
);

    hdd_pkg::hdd_access_t              acc;
    logic [hdd_pkg::DATA_W-1:0]        status;
    logic [hdd_pkg::DATA_W-1:0]        command;
    logic [hdd_pkg::DATA_W-1:0]        exec_rdata;
    logic [hdd_pkg::SECTOR_ADDR_W-1:0] sec_ptr;
    logic                              buf_we;
    logic [hdd_pkg::DATA_W-1:0]        buf_wdata;
    logic [hdd_pkg::DATA_W-1:0]        buf_rdata;

    hdd_bus_decode u_bus_decode (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .phi0          (phi0),
        .DEVICE_SELECT (DEVICE_SELECT),
        .RD            (RD),
        .A             (A),
        .D_IN          (D_IN),
        .acc           (acc)
    );

    hdd_regs u_regs (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .DEVICE_SELECT (DEVICE_SELECT),
        .acc           (acc),
        .status        (status),
        .command       (command),
        .exec_rdata    (exec_rdata),
        .buf_rdata     (buf_rdata),
        .sector        (sector),
        .D_OUT         (D_OUT)
    );

    hdd_cmd_ctrl u_cmd_ctrl (
        .CLK_14M     (CLK_14M),
        .RESET       (RESET),
        .acc         (acc),
        .hdd_mounted (hdd_mounted),
        .hdd_protect (hdd_protect),
        .status      (status),
        .command     (command),
        .exec_rdata  (exec_rdata),
        .sec_ptr     (sec_ptr),
        .buf_we      (buf_we),
        .buf_wdata   (buf_wdata),
        .hdd_read    (hdd_read),
        .hdd_write   (hdd_write)
    );

    // CPU stream on pointer port, host on DMA port
    sector_buffer u_sector_buffer (
        .CLK_14M  (CLK_14M),
        .ptr      (sec_ptr),
        .we       (buf_we),
        .wdata    (buf_wdata),
        .rdata    (buf_rdata),
        .ram_addr (ram_addr),
        .ram_di   (ram_di),
        .ram_we   (ram_we),
        .ram_do   (ram_do)
    );

endmodule

// File: tb/hdd_properties.sv
// ----------------------------------------------------------------------
// HDD interface properties
// Host strobe and idle data bus checks, bound into the top level
// ----------------------------------------------------------------------

module hdd_properties (
    input logic       CLK_14M,
    input logic       RESET,
    input logic       DEVICE_SELECT,
    input logic [7:0] D_OUT,
    input logic       hdd_read,
    input logic       hdd_write
);

    timeunit 1ns;
    timeprecision 100ps;

    // Never both directions at once
    a_strobe_exclusive: assert property (
        @(posedge CLK_14M) disable iff (RESET) !(hdd_read && hdd_write))
    else
        $error("hdd_read and hdd_write high together");

    a_read_one_cycle: assert property (
        @(posedge CLK_14M) disable iff (RESET) hdd_read |=> !hdd_read)
    else
        $error("hdd_read held longer than one clock");

    a_write_one_cycle: assert property (
        @(posedge CLK_14M) disable iff (RESET) hdd_write |=> !hdd_write)
    else
        $error("hdd_write held longer than one clock");

    // Idle bus two clocks after the select drops
    a_idle_ff: assert property (
        @(posedge CLK_14M) disable iff (RESET) $fell(DEVICE_SELECT) |-> ##2 (D_OUT == 8'hFF))
    else
        $error("D_OUT not FF two clocks after DEVICE_SELECT fell");

endmodule

bind hdd_top hdd_properties u_properties (
    .CLK_14M       (CLK_14M),
    .RESET         (RESET),
    .DEVICE_SELECT (DEVICE_SELECT),
    .D_OUT         (D_OUT),
    .hdd_read      (hdd_read),
    .hdd_write     (hdd_write)
);

// File: tb/hdd_tb.sv
// ----------------------------------------------------------------------
// HDD interface testbench
// Random 6502 bus and DMA traffic checked against a register model
// ----------------------------------------------------------------------

module hdd_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        CLK_14M;
    logic        RESET;
    logic        phi0;
    logic        DEVICE_SELECT;
    logic        RD;
    logic [15:0] A;
    logic [7:0]  D_IN;
    logic [7:0]  D_OUT;
    logic [15:0] sector;
    logic        hdd_read;
    logic        hdd_write;
    logic        hdd_mounted;
    logic        hdd_protect;
    logic [8:0]  ram_addr;
    logic [7:0]  ram_di;
    logic [7:0]  ram_do;
    logic        ram_we;

    // ------------------------------------------------------------------
    // Reference model state
    // ------------------------------------------------------------------
    logic [7:0] m_regs [3:7];   // Unit, memory and block bytes
    logic [7:0] m_status;
    logic [7:0] m_command;
    logic [8:0] m_ptr;
    logic [7:0] m_buf [0:511];

    int errors = 0;
    int checks = 0;
    int read_pulses = 0;
    int write_pulses = 0;

    hdd_top u_hdd_top (.*);

    initial
    begin
        CLK_14M = 1'b0;
        forever #10 CLK_14M = ~CLK_14M;
    end

    // Host strobe counters
    always @(posedge CLK_14M)
    begin
        if (!RESET && hdd_read)
            read_pulses <= read_pulses + 1;
        if (!RESET && hdd_write)
            write_pulses <= write_pulses + 1;
    end

    task automatic check_value(input string sig, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    // One select held four clocks, then two idle clocks
    task automatic bus_access(input logic rd, input logic [3:0] off, input logic [7:0] wd,
                              output logic [7:0] rdata);
        A             = {12'hC0B, off};
        RD            = rd;
        D_IN          = wd;
        DEVICE_SELECT = 1'b1;
        phi0          = 1'b1;
        repeat (4) @(negedge CLK_14M);
        rdata         = D_OUT;
        DEVICE_SELECT = 1'b0;
        phi0          = 1'b0;
        RD            = 1'b1;
        repeat (2) @(negedge CLK_14M);
        check_value("D_OUT idle", D_OUT, 8'hFF);
    endtask

    task automatic cpu_write(input logic [3:0] off, input logic [7:0] wd);
        logic [7:0] unused;
        bus_access(1'b0, off, wd, unused);
        case (off)
            4'h2:
            begin
                m_command = wd;
                m_ptr     = '0;
                m_status  = (wd == 8'h01 || wd == 8'h02) ? 8'h80 : 8'h00;
            end
            4'h3, 4'h4, 4'h5, 4'h6, 4'h7: m_regs[off] = wd;
            4'h8:
            begin
                m_buf[m_ptr] = wd;
                m_ptr        = m_ptr + 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic cpu_read(input logic [3:0] off);
        logic [7:0] got;
        logic [7:0] exp;
        bus_access(1'b1, off, 8'h00, got);
        case (off)
            4'h0:
            begin
                // Old status comes back, protected WRITE reports 2B
                exp = (m_command == 8'h02 && hdd_protect) ? 8'h2B : m_status;
                if (m_command == 8'h00)
                    m_status = hdd_mounted ? 8'h00 : 8'h01;
                else if ((m_command == 8'h01 || m_command == 8'h02) && !hdd_mounted)
                    m_status = 8'h01;
                else if (m_command == 8'h02 && hdd_protect)
                    m_status = 8'h01;
            end
            4'h1: exp = m_status;
            4'h2: exp = m_command;
            4'h8:
            begin
                exp = m_buf[m_ptr];
                if (m_ptr == 9'd511)
                    m_status = 8'h00;   // Last byte ends the transfer
                m_ptr = m_ptr + 1'b1;
            end
            default: exp = m_regs[off];
        endcase
        check_value($sformatf("D_OUT[offset %0d]", off), got, exp);
    endtask

    task automatic exec_and_check(input logic [7:0] cmd);
        int rd_base;
        int wr_base;
        int wait_cycles;
        int exp_rd;
        int exp_wr;
        exp_rd = (cmd == 8'h01 && hdd_mounted) ? 1 : 0;
        exp_wr = (cmd == 8'h02 && hdd_mounted && !hdd_protect) ? 1 : 0;
        cpu_write(4'h2, cmd);
        rd_base = read_pulses;
        wr_base = write_pulses;
        cpu_read(4'h0);
        wait_cycles = 0;
        while (read_pulses == rd_base && write_pulses == wr_base && wait_cycles < 16)
        begin
            @(negedge CLK_14M);
            wait_cycles++;
        end
        assert (!((exp_rd + exp_wr) > 0 && read_pulses == rd_base && write_pulses == wr_base))
        else
        begin
            errors++;
            $display("Timed out at %0t waiting for a host strobe after command %h", $time, cmd);
        end
        check_value("hdd_read pulses", 16'(read_pulses - rd_base), 16'(exp_rd));
        check_value("hdd_write pulses", 16'(write_pulses - wr_base), 16'(exp_wr));
        cpu_read(4'h1);
    endtask

    task automatic dma_write(input logic [8:0] addr, input logic [7:0] data);
        ram_addr = addr;
        ram_di   = data;
        ram_we   = 1'b1;
        @(negedge CLK_14M);
        ram_we   = 1'b0;
        m_buf[addr] = data;
    endtask

    // Readback lands two clocks after the address
    task automatic dma_read_check(input logic [8:0] addr);
        ram_addr = addr;
        ram_we   = 1'b0;
        repeat (2) @(negedge CLK_14M);
        check_value($sformatf("ram_do[%0d]", addr), ram_do, m_buf[addr]);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial
    begin
        int seed;
        int n;
        logic [3:0] off;
        logic [7:0] val;
        seed = $urandom(32'h755);
        RESET = 1'b1;
        phi0 = 1'b0;
        DEVICE_SELECT = 1'b0;
        RD = 1'b1;
        A = '0;
        D_IN = '0;
        hdd_mounted = 1'b1;
        hdd_protect = 1'b0;
        ram_addr = '0;
        ram_di = '0;
        ram_we = 1'b0;
        for (int i = 3; i <= 7; i++)
            m_regs[i] = 8'h00;
        m_status  = 8'h00;
        m_command = 8'h00;
        m_ptr     = '0;
        repeat (4) @(negedge CLK_14M);
        RESET = 1'b0;
        check_value("D_OUT after reset", D_OUT, 8'hFF);
        check_value("hdd_read after reset", hdd_read, 1'b0);
        check_value("hdd_write after reset", hdd_write, 1'b0);

        // Parameter registers
        repeat (40)
        begin
            off = 4'(3 + $urandom_range(4));
            val = 8'($urandom);
            cpu_write(off, val);
            cpu_read(4'(3 + $urandom_range(4)));
        end
        check_value("sector", sector, {m_regs[7], m_regs[6]});

        // Command register and status
        for (int i = 0; i < 6; i++)
        begin
            val = (i < 4) ? 8'(i) : 8'($urandom);
            cpu_write(4'h2, val);
            cpu_read(4'h1);
            cpu_read(4'h2);
        end

        // Execute path over mounted and protect
        for (int m = 0; m < 2; m++)
        begin
            for (int p = 0; p < 2; p++)
            begin
                hdd_mounted = m[0];
                hdd_protect = p[0];
                for (int c = 0; c < 3; c++)
                    exec_and_check(8'(c));
            end
        end
        hdd_mounted = 1'b1;
        hdd_protect = 1'b0;

        // Host fills, CPU streams out
        for (int i = 0; i < 512; i++)
            dma_write(9'(i), 8'($urandom));
        cpu_write(4'h2, 8'h01);
        cpu_read(4'h1);
        repeat (512)
            cpu_read(4'h8);
        cpu_read(4'h1);

        // CPU streams in, host reads back
        cpu_write(4'h2, 8'h02);
        n = 16 + $urandom_range(48);
        repeat (n)
            cpu_write(4'h8, 8'($urandom));
        for (int i = 0; i < n; i++)
            dma_read_check(9'(i));
        cpu_read(4'h1);

        // Bus activity without a select
        repeat (20)
        begin
            A    = 16'($urandom);
            RD   = 1'b1;
            phi0 = 1'($urandom);
            @(negedge CLK_14M);
            check_value("D_OUT unselected", D_OUT, 8'hFF);
        end
        phi0 = 1'b0;

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: filelist.f
src/hdd_pkg.sv
src/hdd_bus_decode.sv
src/hdd_regs.sv
src/hdd_cmd_ctrl.sv
src/sector_buffer.sv
src/hdd_top.sv
tb/hdd_properties.sv
tb/hdd_tb.sv
